//--- logic/udp_mux_macros.svh
/*
 * UDP frame multiplexer sizing
 * source count and field widths shared by the package and the RTL
 */
`ifndef UDP_MUX_MACROS_SVH
`define UDP_MUX_MACROS_SVH

// number of source ports feeding the mux
`define UDP_SRC_COUNT 4

// payload data width in bits
`define UDP_DATA_W 8

// header field widths
`define UDP_IP_ADDR_W 32
`define UDP_PORT_W 16

`endif

//--- logic/udp_mux_pkg.sv
/*
 * UDP frame multiplexer types
 * source index and mask, reduced UDP header and payload beat
 */
`include "udp_mux_macros.svh"

package udp_mux_pkg;

    // encoded source number
    typedef logic [$clog2(`UDP_SRC_COUNT)-1:0] src_idx_t;

    // one bit per source
    typedef logic [`UDP_SRC_COUNT-1:0] src_mask_t;

    // reduced header, IP addresses first, then the UDP fields
    typedef struct packed {
        logic [`UDP_IP_ADDR_W-1:0] src_ip;
        logic [`UDP_IP_ADDR_W-1:0] dst_ip;
        logic [`UDP_PORT_W-1:0]    src_port;
        logic [`UDP_PORT_W-1:0]    dst_port;
        logic [`UDP_PORT_W-1:0]    length;
    } udp_hdr_t;

    // one payload beat with end-of-frame and user flag
    typedef struct packed {
        logic [`UDP_DATA_W-1:0] data;
        logic                   last;
        logic                   user;
    } payload_beat_t;

endpackage

//--- logic/rr_arbiter.sv
/*
 * Round-robin arbiter
 * registers a grant for the next requester after the last served source
 * and holds it until the frame owner acknowledges
 */
`timescale 1ns/1ns

module rr_arbiter (
    input  logic                  clk,
    input  logic                  rst,
    input  udp_mux_pkg::src_mask_t request,
    input  logic                  acknowledge,
    output logic                  grant_valid,
    output udp_mux_pkg::src_idx_t  grant_idx
);

    import udp_mux_pkg::*;

    localparam int SRC_COUNT = $bits(src_mask_t);

    src_idx_t last_idx;
    src_idx_t next_idx;
    logic     next_found;

    // cyclic search starting one past the last served source
    always_comb begin : search
        int unsigned cand;

        next_found = 1'b0;
        next_idx   = last_idx;
        for (int i = 1; i <= SRC_COUNT; i++) begin
            cand = (int'(last_idx) + i) % SRC_COUNT;
            if (!next_found && request[cand]) begin
                next_found = 1'b1;
                next_idx   = src_idx_t'(cand);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_valid <= 1'b0;
            grant_idx   <= '0;
            // first search then begins at source 0
            last_idx    <= src_idx_t'(SRC_COUNT - 1);
        end else if (grant_valid && !acknowledge) begin
            // frame in progress, keep the owner
            grant_valid <= 1'b1;
        end else if (next_found) begin
            // idle or releasing, hand over in the same step
            grant_valid <= 1'b1;
            grant_idx   <= next_idx;
            last_idx    <= next_idx;
        end else begin
            grant_valid <= 1'b0;
        end
    end

endmodule

//--- logic/frame_ctrl.sv
/*
 * Frame controller
 * steers the granted source's header and payload into the output
 * registers and tracks frame boundaries for the arbiter
 */
`timescale 1ns/1ns
`include "udp_mux_macros.svh"

module frame_ctrl (
    input  logic                       clk,
    input  logic                       rst,

    input  udp_mux_pkg::src_mask_t      s_hdr_valid,
    output udp_mux_pkg::src_mask_t      s_hdr_ready,
    input  udp_mux_pkg::udp_hdr_t       s_hdr [`UDP_SRC_COUNT],

    input  udp_mux_pkg::src_mask_t      s_payload_valid,
    output udp_mux_pkg::src_mask_t      s_payload_ready,
    input  udp_mux_pkg::payload_beat_t  s_payload [`UDP_SRC_COUNT],

    input  logic                       grant_valid,
    input  udp_mux_pkg::src_idx_t       grant_idx,
    output udp_mux_pkg::src_mask_t      request,
    output logic                       acknowledge,

    output logic                       hdr_push_valid,
    input  logic                       hdr_push_ready,
    output udp_mux_pkg::udp_hdr_t       hdr_push,

    output logic                       beat_push_valid,
    input  logic                       beat_push_ready,
    output udp_mux_pkg::payload_beat_t  beat_push
);

    import udp_mux_pkg::*;

    logic      in_frame;
    src_mask_t grant_mask;
    logic      hdr_push_fire;
    logic      payload_open;
    logic      beat_fire;

    // one-hot copy of the grant, empty while no grant
    assign grant_mask = grant_valid ? (src_mask_t'(1) << grant_idx) : '0;

    // the owner of the current grant does not request again
    assign request = s_hdr_valid & ~grant_mask;

    // header path, only between frames
    assign hdr_push       = s_hdr[grant_idx];
    assign hdr_push_valid = grant_valid && !in_frame && s_hdr_valid[grant_idx];
    assign hdr_push_fire  = hdr_push_valid && hdr_push_ready;
    assign s_hdr_ready    = hdr_push_fire ? grant_mask : '0;

    // payload opens together with the header push so beats never lead it
    assign payload_open = grant_valid && (in_frame || hdr_push_fire);

    assign beat_push       = s_payload[grant_idx];
    assign beat_push_valid = payload_open && s_payload_valid[grant_idx];
    assign beat_fire       = beat_push_valid && beat_push_ready;

    assign s_payload_ready = (payload_open && beat_push_ready) ? grant_mask : '0;

    // release the grant on the final beat
    assign acknowledge = beat_fire && beat_push.last;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame <= 1'b0;
        end else begin
            if (hdr_push_fire) begin
                in_frame <= 1'b1;
            end
            // single-beat frame ends in the cycle it starts
            if (beat_fire && beat_push.last) begin
                in_frame <= 1'b0;
            end
        end
    end

endmodule

//--- logic/skid_register.sv
/*
 * Skid register
 * two-entry valid/ready stage with an output register, a spare entry
 * and a registered input ready, for any packed payload type
 */
`timescale 1ns/1ns

module skid_register #(
    parameter type payload_t = udp_mux_pkg::payload_beat_t
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    payload_t spare_data;
    logic     spare_valid;
    logic     in_ready_early;
    logic     load_out_from_in;
    logic     load_spare_from_in;
    logic     load_out_from_spare;

    // stay ready unless the spare entry is about to fill
    assign in_ready_early = out_ready || (!spare_valid && (!out_valid || !in_valid));

    always_comb begin
        load_out_from_in    = 1'b0;
        load_spare_from_in  = 1'b0;
        load_out_from_spare = 1'b0;
        if (in_ready) begin
            if (out_ready || !out_valid) begin
                load_out_from_in = 1'b1;
            end else begin
                load_spare_from_in = 1'b1;
            end
        end else if (out_ready) begin
            // drain the spare entry first
            load_out_from_spare = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid   <= 1'b0;
            spare_valid <= 1'b0;
            in_ready    <= 1'b0;
        end else begin
            in_ready <= in_ready_early;
            if (load_out_from_in) begin
                out_valid <= in_valid;
            end else if (load_out_from_spare) begin
                out_valid   <= spare_valid;
                spare_valid <= 1'b0;
            end
            if (load_spare_from_in) begin
                spare_valid <= in_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_out_from_in && in_valid) begin
            out_data <= in_data;
        end else if (load_out_from_spare) begin
            out_data <= spare_data;
        end
        if (load_spare_from_in && in_valid) begin
            spare_data <= in_data;
        end
    end

endmodule

//--- logic/udp_arb_mux.sv
/*
 * UDP arbitrated multiplexer
 * four header/payload sources share one output, arbitrated round robin
 * per whole frame, with skid registers on both output channels
 */
`timescale 1ns/1ns
`include "udp_mux_macros.svh"

module udp_arb_mux (
    input  logic                       clk,
    input  logic                       rst,

    // source side
    input  udp_mux_pkg::src_mask_t      s_hdr_valid,
    output udp_mux_pkg::src_mask_t      s_hdr_ready,
    input  udp_mux_pkg::udp_hdr_t       s_hdr [`UDP_SRC_COUNT],
    input  udp_mux_pkg::src_mask_t      s_payload_valid,
    output udp_mux_pkg::src_mask_t      s_payload_ready,
    input  udp_mux_pkg::payload_beat_t  s_payload [`UDP_SRC_COUNT],

    // output side
    output logic                       m_hdr_valid,
    input  logic                       m_hdr_ready,
    output udp_mux_pkg::udp_hdr_t       m_hdr,
    output logic                       m_payload_valid,
    input  logic                       m_payload_ready,
    output udp_mux_pkg::payload_beat_t  m_payload
);

    import udp_mux_pkg::*;

    src_mask_t     request;
    logic          acknowledge;
    logic          grant_valid;
    src_idx_t      grant_idx;

    logic          hdr_push_valid;
    logic          hdr_push_ready;
    udp_hdr_t      hdr_push;
    logic          beat_push_valid;
    logic          beat_push_ready;
    payload_beat_t beat_push;

    rr_arbiter rr_arbiter_i (
        .clk         (clk),
        .rst         (rst),
        .request     (request),
        .acknowledge (acknowledge),
        .grant_valid (grant_valid),
        .grant_idx   (grant_idx)
    );

    frame_ctrl frame_ctrl_i (
        .clk             (clk),
        .rst             (rst),
        .s_hdr_valid     (s_hdr_valid),
        .s_hdr_ready     (s_hdr_ready),
        .s_hdr           (s_hdr),
        .s_payload_valid (s_payload_valid),
        .s_payload_ready (s_payload_ready),
        .s_payload       (s_payload),
        .grant_valid     (grant_valid),
        .grant_idx       (grant_idx),
        .request         (request),
        .acknowledge     (acknowledge),
        .hdr_push_valid  (hdr_push_valid),
        .hdr_push_ready  (hdr_push_ready),
        .hdr_push        (hdr_push),
        .beat_push_valid (beat_push_valid),
        .beat_push_ready (beat_push_ready),
        .beat_push       (beat_push)
    );

    // header output stage
    skid_register #(.payload_t(udp_hdr_t)) hdr_skid_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (hdr_push_valid),
        .in_ready  (hdr_push_ready),
        .in_data   (hdr_push),
        .out_valid (m_hdr_valid),
        .out_ready (m_hdr_ready),
        .out_data  (m_hdr)
    );

    // payload output stage
    skid_register #(.payload_t(payload_beat_t)) payload_skid_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (beat_push_valid),
        .in_ready  (beat_push_ready),
        .in_data   (beat_push),
        .out_valid (m_payload_valid),
        .out_ready (m_payload_ready),
        .out_data  (m_payload)
    );

endmodule

//--- tb/clk_gen.sv
/*
 * Testbench clock and reset
 * 100 ns clock, reset held high for the first 16 rising edges
 */
`timescale 1ns/1ns

module clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- tb/udp_arb_mux_sva.sv
/*
 * Bound assertions for the UDP mux
 * output stability under back-pressure, grant stability, payload ready ownership
 */
`timescale 1ns/1ns

module udp_arb_mux_sva (
    input logic                       clk,
    input logic                       rst,
    input logic                       m_hdr_valid,
    input logic                       m_hdr_ready,
    input udp_mux_pkg::udp_hdr_t      m_hdr,
    input logic                       m_payload_valid,
    input logic                       m_payload_ready,
    input udp_mux_pkg::payload_beat_t m_payload,
    input logic                       grant_valid,
    input udp_mux_pkg::src_idx_t      grant_idx,
    input logic                       acknowledge,
    input udp_mux_pkg::src_mask_t     s_payload_ready
);

    // failed assertions, read by the testbench at the end of the run
    int fail_count = 0;

    hdr_hold: assert property (@(posedge clk) disable iff (rst)
        (m_hdr_valid && !m_hdr_ready) |=> (m_hdr_valid && $stable(m_hdr)))
        else begin
            fail_count++;
            $error("header output changed while stalled");
        end

    payload_hold: assert property (@(posedge clk) disable iff (rst)
        (m_payload_valid && !m_payload_ready) |=> (m_payload_valid && $stable(m_payload)))
        else begin
            fail_count++;
            $error("payload output changed while stalled");
        end

    // owner stays fixed until its last beat
    grant_hold: assert property (@(posedge clk) disable iff (rst)
        (grant_valid && !acknowledge) |=> (grant_valid && $stable(grant_idx)))
        else begin
            fail_count++;
            $error("grant moved before acknowledge");
        end

    ready_owner: assert property (@(posedge clk) disable iff (rst)
        (s_payload_ready != '0) |->
            (grant_valid && $onehot(s_payload_ready) && s_payload_ready[grant_idx]))
        else begin
            fail_count++;
            $error("payload ready given to a source without the grant");
        end

endmodule

bind udp_arb_mux udp_arb_mux_sva udp_arb_mux_sva_i (
    .clk             (clk),
    .rst             (rst),
    .m_hdr_valid     (m_hdr_valid),
    .m_hdr_ready     (m_hdr_ready),
    .m_hdr           (m_hdr),
    .m_payload_valid (m_payload_valid),
    .m_payload_ready (m_payload_ready),
    .m_payload       (m_payload),
    .grant_valid     (grant_valid),
    .grant_idx       (grant_idx),
    .acknowledge     (acknowledge),
    .s_payload_ready (s_payload_ready)
);

//--- tb/udp_arb_mux_tb.sv
/*
 * Testbench for the UDP arbitrated mux
 * runs frame tests from a data file, drives the sources, models the
 * round-robin order and checks every header and payload beat on the output
 */
`timescale 1ns/1ns
`include "udp_mux_macros.svh"

module udp_arb_mux_tb;

    import udp_mux_pkg::*;

    localparam int NSRC = `UDP_SRC_COUNT;

    logic          clk;
    logic          rst;
    src_mask_t     s_hdr_valid;
    src_mask_t     s_hdr_ready;
    udp_hdr_t      s_hdr [NSRC];
    src_mask_t     s_payload_valid;
    src_mask_t     s_payload_ready;
    payload_beat_t s_payload [NSRC];
    logic          m_hdr_valid;
    logic          m_hdr_ready;
    udp_hdr_t      m_hdr;
    logic          m_payload_valid;
    logic          m_payload_ready;
    payload_beat_t m_payload;

    // test state shared by driver, monitor and sequencer
    udp_hdr_t  hdr_tab [NSRC];
    int        beat_k [NSRC];
    src_mask_t launch_mask;
    src_mask_t prev_hdr_ready;
    logic      bp_on;
    int        len_cur;
    // expected source of each frame, in output order
    int        exp_order[$];
    int        hdr_count;
    int        beat_idx;
    int        frames_seen;
    int        errors;
    int        checks;
    int        seed;

    clk_gen clk_gen_i (
        .clk (clk),
        .rst (rst)
    );

    udp_arb_mux udp_arb_mux_i (
        .clk             (clk),
        .rst             (rst),
        .s_hdr_valid     (s_hdr_valid),
        .s_hdr_ready     (s_hdr_ready),
        .s_hdr           (s_hdr),
        .s_payload_valid (s_payload_valid),
        .s_payload_ready (s_payload_ready),
        .s_payload       (s_payload),
        .m_hdr_valid     (m_hdr_valid),
        .m_hdr_ready     (m_hdr_ready),
        .m_hdr           (m_hdr),
        .m_payload_valid (m_payload_valid),
        .m_payload_ready (m_payload_ready),
        .m_payload       (m_payload)
    );

    task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
        checks++;
        if (exp !== act) begin
            $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    // byte k is the low dst_port byte plus k, user only on the last beat
    function automatic payload_beat_t make_beat(input int s, input int k);
        payload_beat_t b;
        b.data = hdr_tab[s].dst_port[7:0] + k[7:0];
        b.last = (k == len_cur - 1);
        b.user = b.last ? s[0] : 1'b0;
        return b;
    endfunction

    task automatic check_idle();
        check("m_hdr_valid", 1'b0, m_hdr_valid);
        check("m_payload_valid", 1'b0, m_payload_valid);
        check("s_hdr_ready", '0, s_hdr_ready);
        check("s_payload_ready", '0, s_payload_ready);
    endtask

    // source driver and output ready generator
    always @(posedge clk) begin
        logic [31:0] rnd;
        if (!rst) begin
            rnd = $random(seed);
            m_hdr_ready     <= bp_on ? rnd[0] : 1'b1;
            m_payload_ready <= bp_on ? rnd[1] : 1'b1;
            for (int s = 0; s < NSRC; s++) begin
                if (launch_mask[s]) begin
                    beat_k[s] = 0;
                    s_hdr[s]           <= hdr_tab[s];
                    s_hdr_valid[s]     <= 1'b1;
                    s_payload[s]       <= make_beat(s, 0);
                    s_payload_valid[s] <= 1'b1;
                end else begin
                    if (s_hdr_valid[s] && s_hdr_ready[s]) begin
                        s_hdr_valid[s] <= 1'b0;
                    end
                    if (s_payload_valid[s] && s_payload_ready[s]) begin
                        if (s_payload[s].last) begin
                            s_payload_valid[s] <= 1'b0;
                        end else begin
                            beat_k[s] = beat_k[s] + 1;
                            s_payload[s] <= make_beat(s, beat_k[s]);
                        end
                    end
                end
            end
        end
    end

    // output monitor, frames leave in the modelled round-robin order
    always @(posedge clk) begin
        payload_beat_t exp_beat;
        if (!rst) begin
            if ((s_hdr_ready & prev_hdr_ready) != '0) begin
                $display("s_hdr_ready stayed high for more than one cycle at %0t ns", $time);
                errors++;
            end
            prev_hdr_ready <= s_hdr_ready;
            if (m_hdr_valid && m_hdr_ready) begin
                if (hdr_count < exp_order.size()) begin
                    check("m_hdr", hdr_tab[exp_order[hdr_count]], m_hdr);
                end else begin
                    $display("unexpected header %h on the output at %0t ns", m_hdr, $time);
                    errors++;
                end
                hdr_count++;
            end
            if (m_payload_valid && m_payload_ready) begin
                if (frames_seen >= exp_order.size()) begin
                    $display("unexpected payload beat on the output at %0t ns", $time);
                    errors++;
                end else begin
                    // under back-pressure the two output channels stall independently
                    if (!bp_on && hdr_count <= frames_seen) begin
                        $display("payload beat left before its header at %0t ns", $time);
                        errors++;
                    end
                    exp_beat = make_beat(exp_order[frames_seen], beat_idx);
                    check("m_payload.data", exp_beat.data, m_payload.data);
                    check("m_payload.last", exp_beat.last, m_payload.last);
                    check("m_payload.user", exp_beat.user, m_payload.user);
                    beat_idx++;
                    if (exp_beat.last) begin
                        beat_idx = 0;
                        frames_seen++;
                    end
                end
            end
        end
    end

    initial begin
        int fd;
        int code;
        int cycles;
        int lines;
        int err_before;
        int s;
        int id;
        int len;
        int bp;
        int nexp;
        int model_last;
        int tests;
        logic [3:0]  mask;
        logic [15:0] order;
        logic [31:0] f_sip;
        logic [31:0] f_dip;
        logic [15:0] f_sp;
        logic [15:0] f_dp;
        logic [15:0] f_len;
        string line;

        seed = 32'h9205;
        errors = 0;
        checks = 0;
        tests = 0;
        model_last = NSRC - 1;
        s_hdr_valid = '0;
        s_payload_valid = '0;
        m_hdr_ready = 1'b0;
        m_payload_ready = 1'b0;
        launch_mask = '0;
        prev_hdr_ready = '0;
        bp_on = 1'b0;
        len_cur = 1;
        hdr_count = 0;
        beat_idx = 0;
        frames_seen = 0;
        for (int i = 0; i < NSRC; i++) begin
            s_hdr[i] = '0;
            s_payload[i] = '0;
            hdr_tab[i] = '0;
            beat_k[i] = 0;
        end

        // outputs stay low through reset and one cycle past it
        cycles = 0;
        @(posedge clk);
        while (rst === 1'b1 && cycles < 40) begin
            @(negedge clk);
            check_idle();
            @(posedge clk);
            cycles++;
        end
        if (rst !== 1'b0) begin
            $display("reset never released");
            errors++;
        end
        @(negedge clk);
        check_idle();

        fd = $fopen("tb/udp_mux_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test file tb/udp_mux_tests.txt");
            errors++;
        end
        lines = 0;
        while (fd != 0 && !$feof(fd) && lines < 1000) begin
            lines++;
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 2 || line[0] == "#") begin
                continue;
            end
            if (line[0] == "H") begin
                code = $sscanf(line, "H %d %h %h %h %h %h", s, f_sip, f_dip, f_sp, f_dp, f_len);
                if (code != 6) begin
                    $display("bad header line: %s", line);
                    errors++;
                end else begin
                    hdr_tab[s] = '{f_sip, f_dip, f_sp, f_dp, f_len};
                end
                continue;
            end
            code = $sscanf(line, "T %d %h %d %d %h", id, mask, len, bp, order);
            if (code != 5) begin
                $display("bad test line: %s", line);
                errors++;
                continue;
            end
            tests++;
            err_before = errors;
            nexp = $countones(mask);

            // round-robin model, search starts after the last served source
            exp_order.delete();
            for (int i = 1; i <= NSRC; i++) begin
                if (mask[(model_last + i) % NSRC]) begin
                    exp_order.push_back((model_last + i) % NSRC);
                end
            end
            model_last = exp_order[nexp - 1];

            len_cur = len;
            hdr_count = 0;
            frames_seen = 0;
            beat_idx = 0;
            @(posedge clk);
            bp_on <= (bp != 0);
            launch_mask <= mask;
            @(posedge clk);
            launch_mask <= '0;

            cycles = 0;
            while ((frames_seen < nexp || hdr_count < nexp) && cycles < 3000) begin
                @(posedge clk);
                cycles++;
            end
            if (frames_seen < nexp || hdr_count < nexp) begin
                $display("test %0d timed out with %0d headers and %0d of %0d frames received",
                         id, hdr_count, frames_seen, nexp);
                errors++;
            end
            bp_on <= 1'b0;
            for (int i = 0; i < nexp; i++) begin
                check("model order", order[4*(nexp-1-i) +: 4], exp_order[i]);
            end
            repeat (2) @(posedge clk);
            $display("test %0d: sources %b, %0d beats, backpressure %0d, %s",
                     id, mask, len, bp, (errors == err_before) ? "ok" : "failed");
        end
        if (fd != 0 && !$feof(fd)) begin
            $display("stopped reading the test file before its end");
            errors++;
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        errors += udp_arb_mux_i.udp_arb_mux_sva_i.fail_count;
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && tests > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+logic
logic/udp_mux_pkg.sv
logic/rr_arbiter.sv
logic/frame_ctrl.sv
logic/skid_register.sv
logic/udp_arb_mux.sv
tb/clk_gen.sv
tb/udp_arb_mux_sva.sv
tb/udp_arb_mux_tb.sv

//--- tb/udp_mux_tests.txt
# H src src_ip dst_ip src_port dst_port length   (header of a source, hex)
# T id src_mask payload_len backpressure expected_order   (runs the test)
# expected_order lists source numbers, first frame out in the leftmost digit
H 0 0a000001 0a0000f0 1000 2010 000d
T 1 1 5 0 0
H 1 0a000102 0b000001 1101 3120 000b
T 2 2 3 0 1
H 2 c0a80003 c0a800ff 1202 4230 0009
T 3 4 1 0 2
H 3 ac100004 ac1000fe 1303 5340 000c
T 4 8 4 0 3
H 0 0a000011 0a000101 2000 6001 000b
H 1 0a000012 0a000102 2001 6102 000b
H 2 0a000013 0a000103 2002 6203 000b
H 3 0a000014 0a000104 2003 6304 000b
T 5 f 3 0 0123
H 0 c0a80101 c0a80201 3000 7050 000a
H 2 c0a80103 c0a80203 3002 7260 000a
T 6 5 2 0 02
H 0 0a010001 0a020001 4000 80a0 000c
H 1 0a010002 0a020002 4001 81b0 000c
H 3 0a010004 0a020004 4003 83c0 000c
T 7 b 4 1 301
H 0 ac110001 ac120001 5000 90e0 000e
H 1 ac110002 ac120002 5001 91e8 000e
H 2 ac110003 ac120003 5002 92f0 000e
H 3 ac110004 ac120004 5003 93f8 000e
T 8 f 6 1 2301
H 1 0a0a0a01 0b0b0b01 6001 a011 0009
H 2 0a0a0a02 0b0b0b02 6002 a122 0009
T 9 6 1 1 21
